// ==== hw/rv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_consts.svh"

module rv_alu (
  input  wire rv_exec_pkg::alu_op_t    opcode,
  input  wire logic [`RV_XLEN-1:0]     operand1,
  input  wire logic [`RV_XLEN-1:0]     operand2,
  output logic [`RV_XLEN-1:0]          result
);

  import rv_exec_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  assign shamt       = operand2[4:0];
  assign lt_signed   = $signed(operand1) < $signed(operand2);
  assign lt_unsigned = operand1 < operand2;
  assign equal       = operand1 == operand2;

  always_comb begin
    result = '0;
    case (opcode)
      ALU_ADD: begin
        result = operand1 + operand2;
      end
      ALU_SUB: begin
        result = operand1 - operand2;
      end
      ALU_SLL: begin
        result = operand1 << shamt;
      end
      ALU_SLT: begin
        result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR: begin
        result = operand1 ^ operand2;
      end
      ALU_SRL: begin
        result = operand1 >> shamt;
      end
      ALU_SRA: begin
        result = $signed(operand1) >>> shamt;
      end
      ALU_OR: begin
        result = operand1 | operand2;
      end
      ALU_AND: begin
        result = operand1 & operand2;
      end
      // ==============================
      // branch compares
      // ==============================
      ALU_EQ:   result = {{(`RV_XLEN-1){1'b0}}, equal};
      ALU_NE:   result = {{(`RV_XLEN-1){1'b0}}, !equal};
      ALU_LT:   result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_GE:   result = {{(`RV_XLEN-1){1'b0}}, !lt_signed};
      ALU_LTU:  result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      ALU_GEU:  result = {{(`RV_XLEN-1){1'b0}}, !lt_unsigned};
      // lui arrives with the upper immediate already in operand2
      ALU_PASS: result = operand2;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_exec_consts.svh ====
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// ==============================
// datapath geometry
// ==============================

// data and address width of the core
`define RV_XLEN 32

// byte distance to the next sequential instruction
`define RV_PC_STEP 4

// ==============================
// trap and bookkeeping
// ==============================

// mcause value for an environment call from M-mode
`define RV_ECALL_CAUSE 11

// default width of the executed instruction count
`define RV_RETIRE_WIDTH 32

`endif

// ==== hw/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

  // alu operations, compares leave their outcome in bit 0
  typedef enum logic [7:0] {
    ALU_ADD  = 8'h00,
    ALU_SUB  = 8'h01,
    ALU_SLL  = 8'h02,
    ALU_SLT  = 8'h03,
    ALU_SLTU = 8'h04,
    ALU_XOR  = 8'h05,
    ALU_SRL  = 8'h06,
    ALU_SRA  = 8'h07,
    ALU_OR   = 8'h08,
    ALU_AND  = 8'h09,
    ALU_EQ   = 8'h10,
    ALU_NE   = 8'h11,
    ALU_LT   = 8'h12,
    ALU_GE   = 8'h13,
    ALU_LTU  = 8'h14,
    ALU_GEU  = 8'h15,
    ALU_PASS = 8'h20
  } alu_op_t;

  typedef enum logic [1:0] {
    OP2_SRC2 = 2'b00,
    OP2_IMM  = 2'b01,
    OP2_CSR  = 2'b10
  } operand2_sel_t;

  typedef enum logic [2:0] {
    NPC_SEQ    = 3'b000,
    NPC_JAL    = 3'b001,
    NPC_JALR   = 3'b010,
    NPC_BRANCH = 3'b011,
    NPC_TRAP   = 3'b100
  } npc_sel_t;

  // register write data source
  typedef enum logic [1:0] {
    WD_ALU  = 2'b00,
    WD_SNPC = 2'b01,
    WD_DNPC = 2'b10,
    WD_CSR  = 2'b11
  } wdata_sel_t;

endpackage

`default_nettype wire

// ==== hw/rv_exec_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exec_top (
  input  wire logic                       clock,
  input  wire logic                       reset,
  input  wire logic                       decode_valid,
  input  wire logic [`RV_XLEN-1:0]        pc,
  input  wire logic [`RV_XLEN-1:0]        imm,
  input  wire logic [`RV_XLEN-1:0]        src1,
  input  wire logic [`RV_XLEN-1:0]        src2,
  input  wire logic [`RV_XLEN-1:0]        csr_src,
  input  wire rv_exec_pkg::alu_op_t       alu_opcode,
  input  wire rv_exec_pkg::operand2_sel_t alu_operand2_sel,
  input  wire rv_exec_pkg::npc_sel_t      npc_sel,
  input  wire rv_exec_pkg::wdata_sel_t    exu_r_wdata_sel,
  input  wire logic                       csr_wdata1_sel,
  input  wire logic                       block,
  output logic [`RV_XLEN-1:0]             alu_result,
  output logic                            npc_valid,
  output logic [`RV_XLEN-1:0]             npc,
  output logic [`RV_XLEN-1:0]             exu_r_wdata,
  output logic [`RV_XLEN-1:0]             csr_wdata1,
  output logic [`RV_XLEN-1:0]             csr_wdata2,
  output logic                            clear_pipeline,
  output logic [`RV_RETIRE_WIDTH-1:0]     retired_count
);

  rv_exu u_rv_exu (
    .clock            (clock),
    .reset            (reset),
    .block            (block),
    .decode_valid     (decode_valid),
    .pc               (pc),
    .imm              (imm),
    .src1             (src1),
    .src2             (src2),
    .csr_src          (csr_src),
    .alu_opcode       (alu_opcode),
    .alu_operand2_sel (alu_operand2_sel),
    .npc_sel          (npc_sel),
    .exu_r_wdata_sel  (exu_r_wdata_sel),
    .csr_wdata1_sel   (csr_wdata1_sel),
    .alu_result       (alu_result),
    .npc_valid        (npc_valid),
    .npc              (npc),
    .exu_r_wdata      (exu_r_wdata),
    .csr_wdata1       (csr_wdata1),
    .csr_wdata2       (csr_wdata2),
    .clear_pipeline   (clear_pipeline)
  );

  // every valid next pc marks one executed instruction
  rv_retire_counter #(
    .COUNT_WIDTH (`RV_RETIRE_WIDTH)
  ) u_rv_retire_counter (
    .clock  (clock),
    .reset  (reset),
    .retire (npc_valid),
    .count  (retired_count)
  );

endmodule

`default_nettype wire

// ==== hw/rv_exu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exu (
  input  wire logic                       clock,
  input  wire logic                       reset,
  input  wire logic                       block,
  input  wire logic                       decode_valid,
  input  wire logic [`RV_XLEN-1:0]        pc,
  input  wire logic [`RV_XLEN-1:0]        imm,
  input  wire logic [`RV_XLEN-1:0]        src1,
  input  wire logic [`RV_XLEN-1:0]        src2,
  input  wire logic [`RV_XLEN-1:0]        csr_src,
  input  wire rv_exec_pkg::alu_op_t       alu_opcode,
  input  wire rv_exec_pkg::operand2_sel_t alu_operand2_sel,
  input  wire rv_exec_pkg::npc_sel_t      npc_sel,
  input  wire rv_exec_pkg::wdata_sel_t    exu_r_wdata_sel,
  input  wire logic                       csr_wdata1_sel,
  output logic [`RV_XLEN-1:0]             alu_result,
  output logic                            npc_valid,
  output logic [`RV_XLEN-1:0]             npc,
  output logic [`RV_XLEN-1:0]             exu_r_wdata,
  output logic [`RV_XLEN-1:0]             csr_wdata1,
  output logic [`RV_XLEN-1:0]             csr_wdata2,
  output logic                            clear_pipeline
);

  import rv_exec_pkg::*;

  localparam logic [`RV_XLEN-1:0] PC_STEP     = `RV_PC_STEP;
  localparam logic [`RV_XLEN-1:0] ECALL_CAUSE = `RV_ECALL_CAUSE;

  alu_op_t              opcode_q;
  logic [`RV_XLEN-1:0]  operand1_q;
  logic [`RV_XLEN-1:0]  operand2_q;
  logic [`RV_XLEN-1:0]  operand2_next;
  logic [`RV_XLEN-1:0]  snpc_q;
  logic [`RV_XLEN-1:0]  dnpc_q;
  logic [`RV_XLEN-1:0]  csr_src_q;
  npc_sel_t             npc_sel_q;
  wdata_sel_t           wdata_sel_q;
  logic                 csr_wdata1_sel_q;
  logic [`RV_XLEN-1:0]  pc_q;

  rv_alu u_rv_alu (
    .opcode   (opcode_q),
    .operand1 (operand1_q),
    .operand2 (operand2_q),
    .result   (alu_result)
  );

  always_comb begin
    case (alu_operand2_sel)
      OP2_IMM: operand2_next = imm;
      OP2_CSR: operand2_next = csr_src;
      default: operand2_next = src2;
    endcase
  end

  // ==============================
  // stage registers
  // ==============================

  // a redirect squashes whatever decode offers in the same cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      npc_valid <= 1'b0;
    end else if (!block) begin
      npc_valid <= decode_valid && !clear_pipeline;
    end
  end

  always_ff @(posedge clock) begin
    if (!block) begin
      opcode_q         <= alu_opcode;
      operand1_q       <= src1;
      operand2_q       <= operand2_next;
      snpc_q           <= pc + PC_STEP;
      dnpc_q           <= pc + imm;
      csr_src_q        <= csr_src;
      npc_sel_q        <= npc_sel;
      wdata_sel_q      <= exu_r_wdata_sel;
      csr_wdata1_sel_q <= csr_wdata1_sel;
      // second stage for the csr write values
      csr_wdata1       <= csr_wdata1_sel_q ? ECALL_CAUSE : alu_result;
      pc_q             <= pc;
      csr_wdata2       <= pc_q;
    end
  end

  // ==============================
  // next pc and write data
  // ==============================
  always_comb begin
    case (npc_sel_q)
      NPC_SEQ:    npc = snpc_q;
      NPC_JAL:    npc = dnpc_q;
      NPC_JALR:   npc = {alu_result[`RV_XLEN-1:1], 1'b0};
      NPC_BRANCH: npc = alu_result[0] ? dnpc_q : snpc_q;
      // ecall and mret take mtvec or mepc from the csr file
      NPC_TRAP:   npc = csr_src_q;
      default:    npc = '0;
    endcase
  end

  always_comb begin
    case (wdata_sel_q)
      WD_ALU:  exu_r_wdata = alu_result;
      WD_SNPC: exu_r_wdata = snpc_q;
      WD_DNPC: exu_r_wdata = dnpc_q;
      default: exu_r_wdata = csr_src_q;
    endcase
  end

  assign clear_pipeline = npc_valid && (npc != snpc_q);

  a_npc_aligned: assert property (@(posedge clock) disable iff (reset)
    npc_valid && !(npc_sel_q inside {NPC_JALR, NPC_TRAP}) |-> npc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hw/rv_retire_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_consts.svh"

module rv_retire_counter #(
  parameter int COUNT_WIDTH = `RV_RETIRE_WIDTH
) (
  input  wire logic                    clock,
  input  wire logic                    reset,
  input  wire logic                    retire,
  output logic [COUNT_WIDTH-1:0]       count
);

  // wraps silently at the counter width
  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else if (retire) begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rv_exec_top.f ====
+incdir+hw
hw/rv_exec_pkg.sv
hw/rv_alu.sv
hw/rv_exu.sv
hw/rv_retire_counter.sv
hw/rv_exec_top.sv
verification/tb_clock_gen.sv
verification/tb_rv_exec.sv

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clock
);

  // 10 ns period, first rising edge at 5 ns
  initial begin
    clock = 1'b0;
    forever begin
      #5 clock = ~clock;
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_rv_exec.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_consts.svh"

module tb_rv_exec;

  import rv_exec_pkg::*;

  localparam int PERIOD = 10;
  // reset, every slot of the six tests, settle cycles and some margin
  localparam int LIMIT_CYCLES = 16 + 17 * 3 * 4 + 5 * 20 + 3 * 100 + 6 * 4 + 50;

  logic clock;
  logic reset = 1'b1;
  logic decode_valid = 1'b0;
  logic block = 1'b0;
  logic csr_wdata1_sel = 1'b0;
  logic [31:0] pc = '0, imm = '0, src1 = '0, src2 = '0, csr_src = '0;
  alu_op_t alu_opcode = ALU_ADD;
  operand2_sel_t alu_operand2_sel = OP2_SRC2;
  npc_sel_t npc_sel = NPC_SEQ;
  wdata_sel_t exu_r_wdata_sel = WD_ALU;
  logic [31:0] alu_result, npc, exu_r_wdata, csr_wdata1, csr_wdata2;
  logic [`RV_RETIRE_WIDTH-1:0] retired_count;
  logic npc_valid, clear_pipeline;

  // ==============================
  // reference model state
  // ==============================
  logic m_started = 1'b0;
  logic m_reset_q = 1'b0;
  logic m_valid = 1'b0;
  int m_accepts = 0;
  alu_op_t m_op;
  npc_sel_t m_nsel;
  wdata_sel_t m_wsel;
  logic m_c1sel;
  logic [31:0] m_a, m_b, m_pc, m_imm, m_csr, m_csr1, m_csr2;
  logic [31:0] exp_alu, exp_npc, exp_wdata;
  logic exp_clear;
  logic [`RV_RETIRE_WIDTH-1:0] m_count = '0;

  logic [31:0] rng = 32'd39253;
  int errors = 0;
  int passed = 0;
  int failed = 0;
  int errors_at_start = 0;
  string test_name = "reset";
  alu_op_t op_list [17] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
    ALU_SRA, ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU, ALU_PASS};

  tb_clock_gen u_tb_clock_gen (.clock(clock));

  rv_exec_top u_rv_exec_top (.*);

  function logic [31:0] rand_word();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // rv32 semantics, compares report their outcome in bit 0
  function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] a, b);
    logic lt;
    logic ltu;
    lt = $signed(a) < $signed(b);
    ltu = a < b;
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_SLL: return a << b[4:0];
      ALU_SLT, ALU_LT: return 32'(lt);
      ALU_SLTU, ALU_LTU: return 32'(ltu);
      ALU_XOR: return a ^ b;
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return 32'($signed(a) >>> b[4:0]);
      ALU_OR: return a | b;
      ALU_AND: return a & b;
      ALU_EQ: return 32'(a == b);
      ALU_NE: return 32'(a != b);
      ALU_GE: return 32'(!lt);
      ALU_GEU: return 32'(!ltu);
      ALU_PASS: return b;
      default: return '0;
    endcase
  endfunction

  task automatic note_mismatch(input string what, input logic [31:0] expected, actual);
    errors++;
    $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
  endtask

  task automatic flag_failure(input string text);
    errors++;
    $display("ERROR in test %s: %s", test_name, text);
  endtask

  always_comb begin
    exp_alu = alu_ref(m_op, m_a, m_b);
    case (m_nsel)
      NPC_SEQ: exp_npc = m_pc + `RV_PC_STEP;
      NPC_JAL: exp_npc = m_pc + m_imm;
      NPC_JALR: exp_npc = exp_alu & ~32'd1;
      NPC_BRANCH: exp_npc = exp_alu[0] ? m_pc + m_imm : m_pc + `RV_PC_STEP;
      NPC_TRAP: exp_npc = m_csr;
      default: exp_npc = '0;
    endcase
    case (m_wsel)
      WD_ALU: exp_wdata = exp_alu;
      WD_SNPC: exp_wdata = m_pc + `RV_PC_STEP;
      WD_DNPC: exp_wdata = m_pc + m_imm;
      default: exp_wdata = m_csr;
    endcase
    exp_clear = m_valid && exp_npc != m_pc + `RV_PC_STEP;
  end

  always @(posedge clock) begin
    m_started <= 1'b1;
    m_reset_q <= reset;
    m_count <= reset ? '0 : m_count + m_valid;
    if (reset) begin
      m_valid <= 1'b0;
    end else if (!block) begin
      m_valid <= decode_valid && !exp_clear;
    end
    if (!block) begin
      m_accepts <= m_accepts + 1;
      m_op <= alu_opcode;
      m_a <= src1;
      m_b <= alu_operand2_sel == OP2_IMM ? imm : alu_operand2_sel == OP2_CSR ? csr_src : src2;
      m_pc <= pc;
      m_imm <= imm;
      m_csr <= csr_src;
      m_nsel <= npc_sel;
      m_wsel <= exu_r_wdata_sel;
      m_c1sel <= csr_wdata1_sel;
      m_csr1 <= m_c1sel ? `RV_ECALL_CAUSE : exp_alu;
      m_csr2 <= m_pc;
    end
  end

  // ==============================
  // checks
  // ==============================
  a_reset: assert property (@(posedge clock) m_started && (reset || m_reset_q)
    |-> !npc_valid && !clear_pipeline && retired_count == '0)
    else flag_failure("npc_valid, clear_pipeline or retired_count not cleared by reset");
  a_alu: assert property (@(posedge clock) m_accepts > 0 |-> alu_result == exp_alu)
    else note_mismatch("alu_result", $sampled(exp_alu), $sampled(alu_result));
  a_npc: assert property (@(posedge clock) m_accepts > 0 |-> npc == exp_npc)
    else note_mismatch("npc", $sampled(exp_npc), $sampled(npc));
  a_wdata: assert property (@(posedge clock) m_accepts > 0 |-> exu_r_wdata == exp_wdata)
    else note_mismatch("exu_r_wdata", $sampled(exp_wdata), $sampled(exu_r_wdata));
  a_valid: assert property (@(posedge clock) m_started |-> npc_valid == m_valid)
    else note_mismatch("npc_valid", $sampled(m_valid), $sampled(npc_valid));
  a_clear: assert property (@(posedge clock) m_started |-> clear_pipeline == exp_clear)
    else note_mismatch("clear_pipeline", $sampled(exp_clear), $sampled(clear_pipeline));
  a_csr1: assert property (@(posedge clock) m_accepts > 1 |-> csr_wdata1 == m_csr1)
    else note_mismatch("csr_wdata1", $sampled(m_csr1), $sampled(csr_wdata1));
  a_csr2: assert property (@(posedge clock) m_accepts > 1 |-> csr_wdata2 == m_csr2)
    else note_mismatch("csr_wdata2", $sampled(m_csr2), $sampled(csr_wdata2));
  a_count: assert property (@(posedge clock) m_started |-> retired_count == m_count)
    else note_mismatch("retired_count", $sampled(m_count), $sampled(retired_count));

  task automatic drive_slot(input alu_op_t op, input operand2_sel_t osel, input npc_sel_t nsel,
                            input logic valid, input logic blk);
    logic [31:0] r;
    r = rand_word();
    @(negedge clock);
    decode_valid = valid;
    block = blk;
    alu_opcode = op;
    alu_operand2_sel = osel;
    npc_sel = nsel;
    exu_r_wdata_sel = wdata_sel_t'(r[1:0]);
    csr_wdata1_sel = r[2];
    pc = rand_word() & ~32'd3;
    // jal and branch targets stay word aligned
    imm = nsel inside {NPC_JAL, NPC_BRANCH} ? rand_word() & ~32'd3 : rand_word();
    src1 = rand_word();
    src2 = r[7:4] == 4'd0 ? src1 : rand_word();
    csr_src = rand_word();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  // lets the last slot drain through both register stages
  task automatic end_test();
    repeat (4) @(posedge clock);
    #1;
    if (errors == errors_at_start) begin
      passed++;
      $display("test %s passed", test_name);
    end else begin
      failed++;
      $display("test %s failed with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic run_random(input string name, input int slots, input int block_mod);
    int burst;
    burst = 0;
    begin_test(name);
    repeat (slots) begin
      if (burst == 0 && block_mod != 0 && rand_word() % block_mod == 0) begin
        burst = 1 + rand_word() % 4;
      end
      drive_slot(op_list[rand_word() % 17], operand2_sel_t'(2'(rand_word() % 3)),
                 npc_sel_t'(3'(rand_word() % 5)), rand_word() % 8 != 0, burst != 0);
      if (burst != 0) begin
        burst--;
      end
    end
    end_test();
  endtask

  initial begin
    begin_test("reset");
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    end_test();
    begin_test("alu");
    foreach (op_list[i]) begin
      for (int s = 0; s < 3; s++) begin
        repeat (4) begin
          drive_slot(op_list[i], operand2_sel_t'(2'(s)), NPC_SEQ, 1'b1, 1'b0);
        end
      end
    end
    end_test();
    begin_test("next_pc");
    for (int n = 0; n < 5; n++) begin
      repeat (20) begin
        drive_slot(op_list[rand_word() % 17], OP2_IMM, npc_sel_t'(3'(n)), 1'b1, 1'b0);
      end
    end
    end_test();
    run_random("write_data_csr", 100, 0);
    run_random("block", 100, 3);
    run_random("retire_count", 100, 5);
    $display("tests passed %0d failed %0d errors %0d", passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * PERIOD);
    $display("timeout: the tests did not complete within %0d cycles", LIMIT_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
